/* project.f */
rtl/cpu_bus_pkg.sv
rtl/vbus_if.sv
rtl/reset_stretch.sv
rtl/cpu_bus_port.sv
rtl/nmi_mailbox.sv
rtl/vbus_arbiter.sv
rtl/dual_cpu_bus_top.sv
verif/tb_clock_gen.sv
verif/tb_dual_cpu_bus.sv

/* rtl/cpu_bus_pkg.sv */
/* Address map and shared types for the dual-CPU bus.
   Both CPUs see the same map; only 0xC000 is the mailbox (exact match). */
`default_nettype none

package cpu_bus_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_W  = 16;   // Z80-style address
    localparam int DATA_W  = 8;
    localparam int VRAM_AW = 11;   // 2 KB shared video RAM

    // ------------------------------
    // Address map
    // ------------------------------
    localparam logic [ADDR_W-1:0] MAILBOX_ADDR = 16'hC000; // R trig partner, W ack own
    localparam logic [ADDR_W-1:0] VREG_BASE    = 16'hC800; // A[10:8] picks register
    localparam logic [ADDR_W-1:0] VRAM_BASE    = 16'hD000; // 0xD000-0xD7FF
    localparam logic [DATA_W-1:0] OPEN_BUS     = 8'hFF;    // Unmapped read value

    // Decoded target of one access
    typedef enum logic [1:0] {
        REG_NONE,
        REG_MAILBOX,
        REG_VREG,
        REG_VRAM
    } region_e;

    // Write-only video registers, index = A[10:8]
    typedef enum logic [2:0] {
        VR_MSB  = 3'd0,  // Attribute MSB
        VR_FSX  = 3'd1,  // Front scroll X
        VR_FSY  = 3'd2,  // Front scroll Y
        VR_B1SX = 3'd3,  // Back scroll X
        VR_B1SY = 3'd4   // Back scroll Y
    } vreg_e;

    localparam int N_VREG = 5;

endpackage

`default_nettype wire

/* rtl/cpu_bus_port.sv */
/* Wishbone classic slave for one CPU. Mailbox and unmapped accesses ack in
   1 cycle; video accesses go through vbus and ack the cycle after gnt.
   stb is ignored while ack is high, so a held stb cannot be acked twice. */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_port (
    input  logic                              clk,
    input  logic                              bus_rst_n,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [cpu_bus_pkg::ADDR_W-1:0]    wb_adr,
    input  logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_w,
    output logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_r,
    output logic                              wb_ack,
    vbus_if.port                              vbus,
    output logic                              nmi_trig,  // Read of mailbox
    output logic                              nmi_ack    // Write of mailbox
);

    localparam int AW  = cpu_bus_pkg::ADDR_W;
    localparam int VAW = cpu_bus_pkg::VRAM_AW;

    cpu_bus_pkg::region_e region;
    logic                 start;   // New transfer accepted this cycle

    // ------------------------------
    // Address decode
    // ------------------------------
    always_comb begin
        if (wb_adr == cpu_bus_pkg::MAILBOX_ADDR)
            region = cpu_bus_pkg::REG_MAILBOX;
        else if (wb_adr[AW-1:VAW] == cpu_bus_pkg::VREG_BASE[AW-1:VAW])
            region = cpu_bus_pkg::REG_VREG;  // 0xC800-0xCFFF
        else if (wb_adr[AW-1:VAW] == cpu_bus_pkg::VRAM_BASE[AW-1:VAW])
            region = cpu_bus_pkg::REG_VRAM;  // 0xD000-0xD7FF
        else
            region = cpu_bus_pkg::REG_NONE;  // Open bus
    end

    // Not while acking or while a video access is still queued
    assign start = wb_cyc && wb_stb && !wb_ack && !vbus.req;

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!bus_rst_n) begin
            wb_ack   <= 1'b0;
            vbus.req <= 1'b0;
            nmi_trig <= 1'b0;
            nmi_ack  <= 1'b0;
        end else begin
            wb_ack   <= 1'b0;  // Pulses by default
            nmi_trig <= 1'b0;
            nmi_ack  <= 1'b0;
            if (vbus.req) begin
                if (vbus.gnt) begin
                    vbus.req <= 1'b0;
                    wb_ack   <= 1'b1;  // Ack on edge after gnt
                end
            end else if (start) begin
                case (region)
                    cpu_bus_pkg::REG_VREG,
                    cpu_bus_pkg::REG_VRAM: vbus.req <= 1'b1;
                    cpu_bus_pkg::REG_MAILBOX: begin
                        wb_ack   <= 1'b1;
                        nmi_trig <= !wb_we;  // Read raises partner NMI
                        nmi_ack  <= wb_we;   // Write clears own NMI
                    end
                    default: wb_ack <= 1'b1;  // Unmapped, ack and drop
                endcase
            end
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            vbus.we     <= wb_we;
            vbus.region <= region;
            vbus.offset <= wb_adr[VAW-1:0];
            vbus.wdata  <= wb_dat_w;
            wb_dat_r    <= cpu_bus_pkg::OPEN_BUS;  // Local regions read 0xFF
        end
        if (vbus.req && vbus.gnt)
            wb_dat_r <= vbus.rdata;  // Capture arbiter data with gnt
    end

    // One ack per transfer, never back to back
    a_ack_single : assert property (@(posedge clk) disable iff (!bus_rst_n)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* rtl/dual_cpu_bus_top.sv */
/* Dual-CPU shared bus controller, one Wishbone classic slave per CPU.
   CPUs pair 0/1, 2/3 for NMI mailbox, so N_CPU must be even. */
`timescale 1ns/1ps
`default_nettype none

module dual_cpu_bus_top #(
    parameter int N_CPU        = 2,
    parameter int RESET_CYCLES = 64
) (
    input  logic                                        clk,
    input  logic                                        RESETn,
    input  logic [N_CPU-1:0]                            wb_cyc,
    input  logic [N_CPU-1:0]                            wb_stb,
    input  logic [N_CPU-1:0]                            wb_we,
    input  logic [N_CPU-1:0][cpu_bus_pkg::ADDR_W-1:0]   wb_adr,
    input  logic [N_CPU-1:0][cpu_bus_pkg::DATA_W-1:0]   wb_dat_w,
    output logic [N_CPU-1:0][cpu_bus_pkg::DATA_W-1:0]   wb_dat_r,
    output logic [N_CPU-1:0]                            wb_ack,
    output logic [N_CPU-1:0]                            nmi_n,
    output logic [cpu_bus_pkg::DATA_W-1:0]              vreg_msb,
    output logic [cpu_bus_pkg::DATA_W-1:0]              vreg_fsx,
    output logic [cpu_bus_pkg::DATA_W-1:0]              vreg_fsy,
    output logic [cpu_bus_pkg::DATA_W-1:0]              vreg_b1sx,
    output logic [cpu_bus_pkg::DATA_W-1:0]              vreg_b1sy
);

    logic             bus_rst_n;  // Stretched reset for all bus logic
    logic [N_CPU-1:0] nmi_trig;
    logic [N_CPU-1:0] nmi_ack;

    vbus_if vbus [N_CPU] ();      // One channel per CPU

    reset_stretch #(.RESET_CYCLES(RESET_CYCLES)) i_reset_stretch (
        .clk       (clk),
        .RESETn    (RESETn),
        .bus_rst_n (bus_rst_n)
    );

    // ------------------------------
    // Per-CPU slave ports
    // ------------------------------
    for (genvar i = 0; i < N_CPU; i++) begin : g_cpu
        cpu_bus_port i_cpu_bus_port (
            .clk       (clk),
            .bus_rst_n (bus_rst_n),
            .wb_cyc    (wb_cyc[i]),
            .wb_stb    (wb_stb[i]),
            .wb_we     (wb_we[i]),
            .wb_adr    (wb_adr[i]),
            .wb_dat_w  (wb_dat_w[i]),
            .wb_dat_r  (wb_dat_r[i]),
            .wb_ack    (wb_ack[i]),
            .vbus      (vbus[i]),
            .nmi_trig  (nmi_trig[i]),
            .nmi_ack   (nmi_ack[i])
        );
    end

    nmi_mailbox #(.N_CPU(N_CPU)) i_nmi_mailbox (
        .clk       (clk),
        .bus_rst_n (bus_rst_n),
        .nmi_trig  (nmi_trig),
        .nmi_ack   (nmi_ack),
        .nmi_n     (nmi_n)
    );

    vbus_arbiter #(.N_CPU(N_CPU)) i_vbus_arbiter (
        .clk       (clk),
        .bus_rst_n (bus_rst_n),
        .vbus      (vbus),
        .vreg_msb  (vreg_msb),
        .vreg_fsx  (vreg_fsx),
        .vreg_fsy  (vreg_fsy),
        .vreg_b1sx (vreg_b1sx),
        .vreg_b1sy (vreg_b1sy)
    );

endmodule

`default_nettype wire

/* rtl/nmi_mailbox.sv */
/* One NMI flag per CPU. CPU i triggers its partner (i ^ 1) and acks itself.
   N_CPU must be even. Trigger beats ack when both land in one cycle. */
`timescale 1ns/1ps
`default_nettype none

module nmi_mailbox #(
    parameter int N_CPU = 2
) (
    input  logic             clk,
    input  logic             bus_rst_n,
    input  logic [N_CPU-1:0] nmi_trig,
    input  logic [N_CPU-1:0] nmi_ack,
    output logic [N_CPU-1:0] nmi_n
);

    logic [N_CPU-1:0] flag;    // NMI pending per CPU
    logic [N_CPU-1:0] set_v;   // Partner triggers, mapped to target

    if (N_CPU % 2 != 0) begin : g_bad_ncpu
        $error("nmi_mailbox needs an even N_CPU");
    end

    always_comb begin
        for (int i = 0; i < N_CPU; i++)
            set_v[i] = nmi_trig[i ^ 1];  // Swap within the pair
    end

    always_ff @(posedge clk) begin
        if (!bus_rst_n)
            flag <= '0;
        else
            flag <= (flag & ~nmi_ack) | set_v;  // Set wins
    end

    assign nmi_n = ~flag;  // Active low to the CPUs

endmodule

`default_nettype wire

/* rtl/reset_stretch.sv */
/* Holds bus_rst_n low for RESET_CYCLES clocks after RESETn goes high.
   RESETn is sampled synchronously; no deassertion filtering beyond the count. */
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
    parameter int RESET_CYCLES = 64
) (
    input  logic clk,
    input  logic RESETn,
    output logic bus_rst_n
);

    localparam int CW = $clog2(RESET_CYCLES + 1);

    logic [CW-1:0] cnt;   // Cycles since RESETn released

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            cnt       <= '0;  // Restart on every low
            bus_rst_n <= 1'b0;
        end else if (cnt != CW'(RESET_CYCLES)) begin
            cnt       <= cnt + 1'b1;
            bus_rst_n <= 1'b0;
        end else begin
            bus_rst_n <= 1'b1; // Count done, release on this edge
        end
    end

    // Bus logic must be back in reset the cycle after RESETn is seen low
    a_rst_follows : assert property (@(posedge clk) !RESETn |=> !bus_rst_n);

endmodule

`default_nettype wire

/* rtl/vbus_arbiter.sv */
/* Round-robin owner of the 2 KB video RAM and the five video registers.
   One grant per cycle, registered, 1 to N_CPU cycles after req.
   Register reads and indices 5-7 return 0xFF; VRAM is not cleared by reset. */
`timescale 1ns/1ps
`default_nettype none

module vbus_arbiter #(
    parameter int N_CPU = 2
) (
    input  logic                            clk,
    input  logic                            bus_rst_n,
    vbus_if.arb                             vbus [N_CPU],
    output logic [cpu_bus_pkg::DATA_W-1:0]  vreg_msb,
    output logic [cpu_bus_pkg::DATA_W-1:0]  vreg_fsx,
    output logic [cpu_bus_pkg::DATA_W-1:0]  vreg_fsy,
    output logic [cpu_bus_pkg::DATA_W-1:0]  vreg_b1sx,
    output logic [cpu_bus_pkg::DATA_W-1:0]  vreg_b1sy
);

    localparam int DW  = cpu_bus_pkg::DATA_W;
    localparam int VAW = cpu_bus_pkg::VRAM_AW;
    localparam int IW  = (N_CPU > 1) ? $clog2(N_CPU) : 1;

    // Flattened view of the port array
    logic [N_CPU-1:0]      req_v;
    logic [N_CPU-1:0]      we_v;
    cpu_bus_pkg::region_e  reg_v [N_CPU];
    logic [VAW-1:0]        off_v [N_CPU];
    logic [DW-1:0]         wd_v  [N_CPU];

    logic [N_CPU-1:0]      gnt_q;
    logic [DW-1:0]         rdata_q;     // Shared by all ports, qualified by gnt
    logic [IW-1:0]         last;        // Last served, lowest priority
    logic [IW-1:0]         sel;
    logic                  sel_valid;
    logic [N_CPU-1:0]      elig;
    cpu_bus_pkg::vreg_e    sel_vreg;

    logic [DW-1:0] vram   [2**VAW];
    logic [DW-1:0] vreg_q [cpu_bus_pkg::N_VREG];

    for (genvar i = 0; i < N_CPU; i++) begin : g_port
        assign req_v[i]      = vbus[i].req;
        assign we_v[i]       = vbus[i].we;
        assign reg_v[i]      = vbus[i].region;
        assign off_v[i]      = vbus[i].offset;
        assign wd_v[i]       = vbus[i].wdata;
        assign vbus[i].gnt   = gnt_q[i];
        assign vbus[i].rdata = rdata_q;
    end

    // ------------------------------
    // Round-robin pick
    // ------------------------------
    assign elig = req_v & ~gnt_q;  // Port still holds req during its gnt cycle

    always_comb begin
        int idx;
        sel_valid = 1'b0;
        sel       = last;
        for (int k = 1; k <= N_CPU; k++) begin
            idx = (int'(last) + k) % N_CPU;  // Start just after last winner
            if (!sel_valid && elig[idx]) begin
                sel_valid = 1'b1;
                sel       = IW'(idx);
            end
        end
    end

    assign sel_vreg = cpu_bus_pkg::vreg_e'(off_v[sel][VAW-1:8]);  // A[10:8]

    // ------------------------------
    // Grant and register file
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!bus_rst_n) begin
            gnt_q <= '0;
            last  <= '0;
            for (int r = 0; r < cpu_bus_pkg::N_VREG; r++)
                vreg_q[r] <= '0;
        end else begin
            gnt_q <= '0;
            if (sel_valid) begin
                gnt_q[sel] <= 1'b1;
                last       <= sel;
                if (we_v[sel] && reg_v[sel] == cpu_bus_pkg::REG_VREG
                        && int'(sel_vreg) < cpu_bus_pkg::N_VREG)
                    vreg_q[sel_vreg] <= wd_v[sel];  // 5-7 dropped
            end
        end
    end

    // Video RAM and read data
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            if (reg_v[sel] == cpu_bus_pkg::REG_VRAM) begin
                if (we_v[sel])
                    vram[off_v[sel]] <= wd_v[sel];
                rdata_q <= vram[off_v[sel]];
            end else begin
                rdata_q <= cpu_bus_pkg::OPEN_BUS;  // Registers are write-only
            end
        end
    end

    assign vreg_msb  = vreg_q[cpu_bus_pkg::VR_MSB];
    assign vreg_fsx  = vreg_q[cpu_bus_pkg::VR_FSX];
    assign vreg_fsy  = vreg_q[cpu_bus_pkg::VR_FSY];
    assign vreg_b1sx = vreg_q[cpu_bus_pkg::VR_B1SX];
    assign vreg_b1sy = vreg_q[cpu_bus_pkg::VR_B1SY];

    // Shared rdata only works with one winner per cycle
    a_gnt_onehot : assert property (@(posedge clk) disable iff (!bus_rst_n)
        $onehot0(gnt_q));

endmodule

`default_nettype wire

/* rtl/vbus_if.sv */
/* Request channel from one CPU port to the video bus arbiter.
   req and its fields stay put until gnt; gnt is one cycle, rdata valid with it. */
`timescale 1ns/1ps
`default_nettype none

interface vbus_if;

    logic                                req;     // Held until gnt
    logic                                we;
    cpu_bus_pkg::region_e                region;  // REG_VREG or REG_VRAM only
    logic [cpu_bus_pkg::VRAM_AW-1:0]     offset;  // Low address bits
    logic [cpu_bus_pkg::DATA_W-1:0]      wdata;

    logic                                gnt;     // Single-cycle grant
    logic [cpu_bus_pkg::DATA_W-1:0]      rdata;   // Valid with gnt

    // CPU side
    modport port (
        output req, we, region, offset, wdata,
        input  gnt, rdata
    );

    // Arbiter side
    modport arb (
        input  req, we, region, offset, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_dual_cpu_bus -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }

grep -qxF '** PASS **' "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

/* verif/tb_clock_gen.sv */
/* Clock and power-on reset for simulation only.
   RESETn is released 1 ns after a rising edge, never on the edge itself. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20,  // ns, 40 ns period
    parameter int RESET_LEN   = 10   // Cycles of RESETn low
) (
    output logic clk,
    output logic RESETn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        RESETn = 1'b0;
        repeat (RESET_LEN) @(posedge clk);
        #1 RESETn = 1'b1;  // Off the edge, like all stimulus
    end

endmodule

`default_nettype wire

/* verif/tb_dual_cpu_bus.sv */
/* Testbench for the dual-CPU bus with N_CPU = 2. All stimulus changes 1 ns after
   a rising edge; results are checked at the falling edge in ack order. */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_cpu_bus;

    localparam int N_CPU        = 2;
    localparam int RESET_CYCLES = 64;
    localparam int ACK_TIMEOUT  = 200;  // Cycles, covers the reset stretch
    localparam int AW           = cpu_bus_pkg::ADDR_W;
    localparam int DW           = cpu_bus_pkg::DATA_W;
    localparam int VAW          = cpu_bus_pkg::VRAM_AW;

    typedef struct packed {
        int            cpu;
        logic          we;
        logic [AW-1:0] adr;
        logic [DW-1:0] data;  // Write data, or data read back
    } xfer_t;

    logic                        clk;
    logic                        RESETn;
    logic [N_CPU-1:0]            wb_cyc;
    logic [N_CPU-1:0]            wb_stb;
    logic [N_CPU-1:0]            wb_we;
    logic [N_CPU-1:0][AW-1:0]    wb_adr;
    logic [N_CPU-1:0][DW-1:0]    wb_dat_w;
    logic [N_CPU-1:0][DW-1:0]    wb_dat_r;
    logic [N_CPU-1:0]            wb_ack;
    logic [N_CPU-1:0]            nmi_n;
    logic [DW-1:0]               vreg_msb;
    logic [DW-1:0]               vreg_fsx;
    logic [DW-1:0]               vreg_fsy;
    logic [DW-1:0]               vreg_b1sx;
    logic [DW-1:0]               vreg_b1sy;

    // Reference model state
    logic [DW-1:0] vram_model [2**VAW];
    logic [DW-1:0] vreg_model [cpu_bus_pkg::N_VREG] = '{default: '0};
    logic [N_CPU-1:0] exp_nmi_n = '1;

    xfer_t done_q [$];                 // Finished transfers, in ack order
    int    issued [N_CPU] = '{default: 0};
    int    acked  [N_CPU] = '{default: 0};
    int    checks = 0;
    int    errors = 0;

    tb_clock_gen #(.HALF_PERIOD(20), .RESET_LEN(10)) i_clock_gen (
        .clk    (clk),
        .RESETn (RESETn)
    );

    dual_cpu_bus_top #(.N_CPU(N_CPU), .RESET_CYCLES(RESET_CYCLES)) i_dual_cpu_bus_top (
        .clk(clk), .RESETn(RESETn),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .nmi_n(nmi_n),
        .vreg_msb(vreg_msb), .vreg_fsx(vreg_fsx), .vreg_fsy(vreg_fsy),
        .vreg_b1sx(vreg_b1sx), .vreg_b1sy(vreg_b1sy)
    );

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [AW-1:0] vram_addr(input logic [VAW-1:0] off);
        return {cpu_bus_pkg::VRAM_BASE[AW-1:VAW], off};
    endfunction

    // Expected read data from the address map
    function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] adr);
        if (adr[AW-1:VAW] == cpu_bus_pkg::VRAM_BASE[AW-1:VAW])
            return vram_model[adr[VAW-1:0]];
        return cpu_bus_pkg::OPEN_BUS;  // Mailbox, write-only regs, unmapped
    endfunction

    function automatic void update_model(input xfer_t x);
        if (x.adr == cpu_bus_pkg::MAILBOX_ADDR) begin
            if (x.we)
                exp_nmi_n[x.cpu] = 1'b1;      // Own NMI released
            else
                exp_nmi_n[x.cpu ^ 1] = 1'b0;  // Partner NMI raised
        end else if (x.we && x.adr[AW-1:VAW] == cpu_bus_pkg::VRAM_BASE[AW-1:VAW]) begin
            vram_model[x.adr[VAW-1:0]] = x.data;
        end else if (x.we && x.adr[AW-1:VAW] == cpu_bus_pkg::VREG_BASE[AW-1:VAW]
                && int'(x.adr[10:8]) < cpu_bus_pkg::N_VREG) begin
            vreg_model[x.adr[10:8]] = x.data;  // Index from A[10:8]
        end
    endfunction

    function automatic void compare_outputs();
        logic [5*DW-1:0] got;
        logic [5*DW-1:0] exp;
        got = {vreg_b1sy, vreg_b1sx, vreg_fsy, vreg_fsx, vreg_msb};
        exp = {vreg_model[4], vreg_model[3], vreg_model[2], vreg_model[1], vreg_model[0]};
        checks += 2;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: video registers %h, expected %h", $time, got, exp);
        end
        if (nmi_n !== exp_nmi_n) begin
            errors++;
            $display("FAILED at %0t: nmi_n %b, expected %b", $time, nmi_n, exp_nmi_n);
        end
    endfunction

    // Compare process, one falling edge after each ack
    always @(negedge clk) begin
        xfer_t x;
        while (done_q.size() > 0) begin
            x = done_q.pop_front();
            if (!x.we) begin
                checks++;
                if (x.data !== expected_read(x.adr)) begin
                    errors++;
                    $display("FAILED at %0t: CPU %0d read %h = %h, expected %h",
                             $time, x.cpu, x.adr, x.data, expected_read(x.adr));
                end
            end
            update_model(x);
        end
    end

    always @(negedge clk) begin
        for (int i = 0; i < N_CPU; i++)
            if (wb_ack[i])
                acked[i]++;  // Every ack pulse, wanted or not
    end

    // ------------------------------
    // Wishbone master side
    // ------------------------------
    task automatic abort_run(input string why);
        errors++;
        $display("%s, stopped at %0t", why, $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    endtask

    // Call 1 ns after a rising edge; returns 1 ns after the ack edge
    task automatic bus_access(input int cpu, input logic we, input logic [AW-1:0] adr,
                              input logic [DW-1:0] wdata, output int cycles);
        xfer_t x;
        logic  got;
        got    = 1'b0;
        cycles = 0;
        issued[cpu]++;
        wb_cyc[cpu]   = 1'b1;
        wb_stb[cpu]   = 1'b1;
        wb_we[cpu]    = we;
        wb_adr[cpu]   = adr;
        wb_dat_w[cpu] = wdata;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            got = wb_ack[cpu];
        end
        wb_cyc[cpu] = 1'b0;
        wb_stb[cpu] = 1'b0;
        if (!got) begin
            abort_run($sformatf("CPU %0d got no ack for address %h", cpu, adr));
        end else begin
            x.cpu  = cpu;
            x.we   = we;
            x.adr  = adr;
            x.data = we ? wdata : wb_dat_r[cpu];  // dat_r valid with ack
            done_q.push_back(x);
        end
    endtask

    // Outputs after the mailbox edge, then back on the drive phase
    task automatic check_outputs();
        @(posedge clk);
        @(negedge clk);
        #1;
        compare_outputs();
        @(posedge clk);
        #1;
    endtask

    // Random traffic in a 32-byte window, writes only to the own half
    task automatic run_traffic(input int cpu, input int n_ops);
        logic [VAW-1:0] off;
        logic           we;
        int             cyc;
        for (int i = 0; i < n_ops; i++) begin
            we  = 1'($urandom);
            off = {1'($urandom), 6'b0, 4'($urandom)};
            if (we)
                off[VAW-1] = cpu[0];
            bus_access(cpu, we, vram_addr(off), 8'($urandom), cyc);
            checks++;
            if (cyc > N_CPU + 3) begin
                errors++;
                $display("FAILED at %0t: CPU %0d video access took %0d cycles", $time, cpu, cyc);
            end
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [AW-1:0] wr_q [$];
        logic [AW-1:0] adr;
        int            cyc;
        int            n;
        void'($urandom(32'ha9a7));
        wb_cyc   = '0;
        wb_stb   = '0;
        wb_we    = '0;
        wb_adr   = '0;
        wb_dat_w = '0;

        n = 0;  // Reset, then an access inside the stretch
        do begin
            @(negedge clk);
            n++;
            if (n > 50)
                abort_run("RESETn never went high");
        end while (!RESETn);
        compare_outputs();
        @(posedge clk);
        #1;
        bus_access(0, 1'b0, 16'h0000, 8'h00, cyc);
        checks++;
        if (cyc < RESET_CYCLES || cyc > RESET_CYCLES + 4) begin
            errors++;
            $display("FAILED at %0t: first ack after %0d cycles", $time, cyc);
        end

        for (int i = 0; i < 16; i++) begin  // CPU 0 writes, CPU 1 reads back
            adr = vram_addr(VAW'($urandom));
            wr_q.push_back(adr);
            bus_access(0, 1'b1, adr, 8'($urandom), cyc);
        end
        foreach (wr_q[i])
            bus_access(1, 1'b0, wr_q[i], 8'h00, cyc);

        for (int i = 0; i < 32; i++)  // Preload the traffic window
            bus_access(0, 1'b1, vram_addr({i[4], 6'b0, i[3:0]}), 8'($urandom), cyc);
        fork
            run_traffic(0, 24);
            run_traffic(1, 24);
        join

        for (int r = 0; r < 8; r++)  // Registers, 5 to 7 unused
            bus_access(r % 2, 1'b1, {cpu_bus_pkg::VREG_BASE[AW-1:VAW], 3'(r), 8'($urandom)},
                       8'($urandom), cyc);
        check_outputs();
        for (int r = 0; r < 8; r++)
            bus_access((r + 1) % 2, 1'b0, {cpu_bus_pkg::VREG_BASE[AW-1:VAW], 3'(r), 8'hFF},
                       8'h00, cyc);

        for (int c = 0; c < N_CPU; c++) begin  // Mailbox, both directions
            bus_access(c, 1'b0, cpu_bus_pkg::MAILBOX_ADDR, 8'h00, cyc);
            check_outputs();
            bus_access(c ^ 1, 1'b1, cpu_bus_pkg::MAILBOX_ADDR, 8'h00, cyc);
            check_outputs();
        end

        bus_access(0, 1'b0, 16'h0000, 8'h00, cyc);  // Open bus
        bus_access(1, 1'b0, 16'hE000, 8'h00, cyc);
        bus_access(0, 1'b1, 16'h0000, 8'h5A, cyc);
        bus_access(1, 1'b1, 16'hD800, 8'hA5, cyc);  // Just past the RAM
        check_outputs();
        bus_access(0, 1'b0, 16'hD000, 8'h00, cyc);  // Alias target unchanged

        @(negedge clk);
        #1;
        for (int i = 0; i < N_CPU; i++) begin
            checks++;
            if (acked[i] != issued[i]) begin
                errors++;
                $display("FAILED at %0t: CPU %0d saw %0d acks for %0d transfers",
                         $time, i, acked[i], issued[i]);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
